/* Bender.yml */
package:
  name: mmc_init_controller

sources:
  - mmc_init_pkg.sv
  - mmc_command_encoder.sv
  - mmc_init_sequencer.sv
  - mmc_card_registers.sv
  - mmc_init_controller.sv
  - target: test
    files:
      - mmc_card_model.sv
      - tb_mmc_init_controller.sv

/* mmc_card_model.sv */
//**************************************************
// Command layer and card model for the testbench
// Answers each frame after a random busy time
//**************************************************
`default_nettype none

module mmc_card_model
    import mmc_init_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        start_command,
    input  cmd_req_t    cmd_req,
    output logic        command_busy,
    output response_t   response,
    output logic        response_error,
    output logic        timeout_interrupt,
    // Card profile
    input  logic        card_is_mmc,
    input  int          not_ready_count,
    input  logic        bad_echo_once,
    input  ocr_t        card_ocr,
    input  card_id_t    card_cid,
    input  card_id_t    card_csd,
    input  rca_t        card_rca,
    // One pulse per accepted frame
    output logic        frame_strobe,
    output cmd_req_t    request_seen
);

    integer      seed;
    int          busy_left;
    int          op_cond_replies;
    logic        echo_failed;

    task automatic answer(input logic [47:0] sent);
        cmd_index_t index;
        index    = sent[45:40];
        response = '0;
        case (index)
            cmd_send_if_cond: begin
                // MMC cards stay silent on CMD8
                if (card_is_mmc) begin
                    timeout_interrupt = 1'b1;
                end else if (bad_echo_once && !echo_failed) begin
                    echo_failed     = 1'b1;
                    response[19:8]  = 12'h0AA;
                end else begin
                    response[19:8]  = 12'h1AA;
                end
            end
            acmd_sd_send_op_cond, cmd_send_op_cond: begin
                if (op_cond_replies < not_ready_count)
                    response[39:8] = card_ocr & 32'h7FFF_FFFF;
                else
                    response[39:8] = card_ocr;
                op_cond_replies++;
            end
            cmd_all_send_cid:       response[127:0] = card_cid;
            cmd_send_relative_addr: if (!card_is_mmc) response[39:24] = card_rca;
            cmd_send_csd:           response[127:0] = card_csd;
            default: begin
            end
        endcase
    endtask

    initial begin
        seed              = 32'h4f96;
        command_busy      = 1'b0;
        response          = '0;
        response_error    = 1'b0;
        timeout_interrupt = 1'b0;
        frame_strobe      = 1'b0;
        request_seen      = '0;
        busy_left         = 0;
        op_cond_replies   = 0;
        echo_failed       = 1'b0;
    end

    always @(negedge clock) begin
        frame_strobe = 1'b0;
        if (reset) begin
            command_busy      = 1'b0;
            response          = '0;
            response_error    = 1'b0;
            timeout_interrupt = 1'b0;
            op_cond_replies   = 0;
            echo_failed       = 1'b0;
        end else if (command_busy) begin
            if (busy_left > 1) begin
                busy_left--;
            end else begin
                command_busy = 1'b0;
                answer(request_seen.frame);
            end
        end else if (start_command) begin
            request_seen      = cmd_req;
            frame_strobe      = 1'b1;
            command_busy      = 1'b1;
            response_error    = 1'b0;
            timeout_interrupt = 1'b0;
            busy_left         = 1 + ($unsigned($random(seed)) % 6);
        end
    end

endmodule

`default_nettype wire

/* mmc_card_registers.sv */
//************************************************
// MMC/SD card register block
// Holds OCR, CID, RCA and CSD and decodes the
// status bits of the current response
//************************************************
`default_nettype none

module mmc_card_registers
    import mmc_init_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  response_t    response,
    input  capture_sel_t capture_sel,
    input  logic         mmc_mode,
    output ocr_t         ocr,
    output card_id_t     cid,
    output card_id_t     csd,
    output rca_t         rca,
    output logic         echo_ok,
    output logic         power_up_done,
    output logic         rca_status_error,
    output logic         select_status_error
);

    // OCR from ACMD41 or CMD1
    always_ff @(posedge clock) begin
        if (reset)
            ocr <= '0;
        else if (capture_sel == cap_ocr)
            ocr <= response[39:8];
    end

    always_ff @(posedge clock) begin
        if (reset)
            cid <= '0;
        else if (capture_sel == cap_cid)
            cid <= response[127:0];
    end

    always_ff @(posedge clock) begin
        if (reset)
            csd <= '0;
        else if (capture_sel == cap_csd)
            csd <= response[127:0];
    end

    // MMC keeps the host-assigned default address
    always_ff @(posedge clock) begin
        if (reset)
            rca <= mmc_default_rca;
        else if (capture_sel == cap_rca && !mmc_mode)
            rca <= response[39:24];
    end

    // Status decode
    assign echo_ok             = (response[19:8] == if_cond_arg[11:0]);
    assign power_up_done       = response[39];
    assign rca_status_error    = response[21];
    assign select_status_error = response[27];

    a_no_rca_capture_in_mmc: assert property (@(posedge clock) disable iff (reset)
        capture_sel == cap_rca |-> !mmc_mode);

endmodule

`default_nettype wire

/* mmc_command_encoder.sv */
//************************************************
// MMC/SD command encoder
// Builds the 48-bit frame, CRC enables and response
// length for the selected initialization command
//************************************************
`default_nettype none

module mmc_command_encoder
    import mmc_init_pkg::*;
(
    input  cmd_sel_t cmd_sel,
    input  rca_t     rca,
    input  logic     mmc_mode,
    output cmd_req_t cmd_req
);

    cmd_index_t    index;
    card_arg_t     arg;
    logic          response_crc;
    response_len_t length;
    logic          dummy;

    always_comb begin
        index        = cmd_go_idle;
        arg          = '0;
        response_crc = 1'b1;
        length       = short_response_len;
        dummy        = 1'b0;

        case (cmd_sel)
            sel_cmd0: begin
                index        = cmd_go_idle;
                response_crc = 1'b0;
                length       = '0;
            end
            sel_cmd8: begin
                index = cmd_send_if_cond;
                arg   = if_cond_arg;
            end
            sel_cmd55: begin
                index = cmd_app_cmd;
            end
            sel_acmd41: begin
                index = acmd_sd_send_op_cond;
                arg   = op_cond_arg;
            end
            sel_cmd1: begin
                index = cmd_send_op_cond;
                arg   = op_cond_arg;
            end
            sel_cmd2: begin
                index  = cmd_all_send_cid;
                length = long_response_len;
            end
            sel_cmd3: begin
                index = cmd_send_relative_addr;
                // MMC gets its address assigned by the host
                if (mmc_mode)
                    arg = {mmc_default_rca, 16'h0000};
            end
            sel_cmd9: begin
                index  = cmd_send_csd;
                arg    = {rca, 16'h0000};
                length = long_response_len;
            end
            sel_cmd7: begin
                index = cmd_select_card;
                arg   = {rca, 16'h0000};
            end
            default: begin
                dummy = 1'b1;
            end
        endcase
    end

    always_comb begin
        if (dummy) begin
            cmd_req.frame               = '1;
            cmd_req.enable_command_crc  = 1'b0;
            cmd_req.enable_response_crc = 1'b0;
            cmd_req.response_length     = '0;
        end else begin
            // CRC byte left zero for the command layer
            cmd_req.frame               = {2'b01, index, arg, 8'h00};
            cmd_req.enable_command_crc  = 1'b1;
            cmd_req.enable_response_crc = response_crc;
            cmd_req.response_length     = length;
        end
    end

endmodule

`default_nettype wire

/* mmc_init_controller.f */
mmc_init_pkg.sv
mmc_command_encoder.sv
mmc_init_sequencer.sv
mmc_card_registers.sv
mmc_init_controller.sv
mmc_card_model.sv
tb_mmc_init_controller.sv

/* mmc_init_controller.sv */
//************************************************
// MMC/SD initialization controller top level
// Sequencer, command encoder and card registers
//************************************************
`default_nettype none

module mmc_init_controller
    import mmc_init_pkg::*;
(
    input  logic         clock,
    input  logic         reset,

    // Command layer
    output logic         reset_command_state,
    output logic         start_command,
    output cmd_req_t     cmd_req,
    input  logic         command_busy,
    input  response_t    response,
    input  logic         response_error,
    input  logic         timeout_interrupt,

    // Card interface and status
    output clock_cycle_t mmc_clock_cycle,
    output logic         card_ready,
    output ocr_t         ocr,
    output card_id_t     cid,
    output card_id_t     csd,
    output rca_t         rca
);

    cmd_sel_t     cmd_sel;
    capture_sel_t capture_sel;
    logic         mmc_mode;
    logic         echo_ok;
    logic         power_up_done;
    logic         rca_status_error;
    logic         select_status_error;

    mmc_init_sequencer u_mmc_init_sequencer (
        .clock               (clock),
        .reset               (reset),
        .command_busy        (command_busy),
        .response_error      (response_error),
        .timeout_interrupt   (timeout_interrupt),
        .echo_ok             (echo_ok),
        .power_up_done       (power_up_done),
        .rca_status_error    (rca_status_error),
        .select_status_error (select_status_error),
        .reset_command_state (reset_command_state),
        .start_command       (start_command),
        .cmd_sel             (cmd_sel),
        .capture_sel         (capture_sel),
        .mmc_mode            (mmc_mode),
        .mmc_clock_cycle     (mmc_clock_cycle),
        .card_ready          (card_ready)
    );

    mmc_command_encoder u_mmc_command_encoder (
        .cmd_sel  (cmd_sel),
        .rca      (rca),
        .mmc_mode (mmc_mode),
        .cmd_req  (cmd_req)
    );

    mmc_card_registers u_mmc_card_registers (
        .clock               (clock),
        .reset               (reset),
        .response            (response),
        .capture_sel         (capture_sel),
        .mmc_mode            (mmc_mode),
        .ocr                 (ocr),
        .cid                 (cid),
        .csd                 (csd),
        .rca                 (rca),
        .echo_ok             (echo_ok),
        .power_up_done       (power_up_done),
        .rca_status_error    (rca_status_error),
        .select_status_error (select_status_error)
    );

endmodule

`default_nettype wire

/* mmc_init_pkg.sv */
//************************************************
// MMC/SD initialization shared definitions
// Divider values, command encodings, FSM states
// and the command request passed to the command layer
//************************************************
`default_nettype none

package mmc_init_pkg;

    typedef logic [7:0]   clock_cycle_t;
    typedef logic [31:0]  card_arg_t;
    typedef logic [15:0]  rca_t;
    typedef logic [31:0]  ocr_t;
    typedef logic [127:0] card_id_t;
    typedef logic [135:0] response_t;
    typedef logic [4:0]   response_len_t;
    typedef logic [5:0]   cmd_index_t;

    // Serial clock divider
    localparam clock_cycle_t init_spi_clock_cycle   = 8'd10;
    localparam clock_cycle_t normal_spi_clock_cycle = 8'd2;

    // Dummy clocking frames sent before CMD0
    localparam logic [1:0] reset_pulse_total = 2'd2;

    // Command indices
    localparam cmd_index_t cmd_go_idle            = 6'd0;
    localparam cmd_index_t cmd_send_op_cond       = 6'd1;
    localparam cmd_index_t cmd_all_send_cid       = 6'd2;
    localparam cmd_index_t cmd_send_relative_addr = 6'd3;
    localparam cmd_index_t cmd_select_card        = 6'd7;
    localparam cmd_index_t cmd_send_if_cond       = 6'd8;
    localparam cmd_index_t cmd_send_csd           = 6'd9;
    localparam cmd_index_t cmd_app_cmd            = 6'd55;
    localparam cmd_index_t acmd_sd_send_op_cond   = 6'd41;

    // Arguments
    localparam card_arg_t if_cond_arg     = 32'h0000_01AA;
    localparam card_arg_t op_cond_arg     = 32'h40FF_8000;
    localparam rca_t      mmc_default_rca = 16'h0001;

    // Response lengths in bytes
    localparam response_len_t short_response_len = 5'd6;
    localparam response_len_t long_response_len  = 5'd17;

    typedef enum logic [3:0] {
        sel_none, sel_dummy, sel_cmd0, sel_cmd8, sel_cmd55, sel_acmd41,
        sel_cmd1, sel_cmd2, sel_cmd3, sel_cmd9, sel_cmd7
    } cmd_sel_t;

    typedef enum logic [2:0] {
        cap_none, cap_ocr, cap_cid, cap_rca, cap_csd
    } capture_sel_t;

    typedef enum logic [4:0] {
        st_init, st_reset_clk_1, st_reset_clk_2,
        st_send_cmd0, st_wait_cmd0, st_send_dummy, st_wait_dummy,
        st_send_cmd8, st_resp_cmd8, st_send_cmd55, st_resp_cmd55,
        st_send_acmd41, st_resp_acmd41, st_send_cmd1, st_resp_cmd1,
        st_send_init_dummy, st_wait_init_dummy,
        st_send_cmd2, st_resp_cmd2, st_send_cmd3, st_resp_cmd3,
        st_send_cmd9, st_resp_cmd9, st_send_cmd7, st_resp_cmd7, st_ready
    } init_state_t;

    typedef struct packed {
        logic [47:0]   frame;
        logic          enable_command_crc;
        logic          enable_response_crc;
        response_len_t response_length;
    } cmd_req_t;

endpackage

`default_nettype wire

/* mmc_init_sequencer.sv */
//************************************************
// MMC/SD card initialization sequencer
// Steps through bring-up one command at a time,
// falling back to the MMC path on a CMD8 timeout
//************************************************
`default_nettype none

module mmc_init_sequencer
    import mmc_init_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         command_busy,
    input  logic         response_error,
    input  logic         timeout_interrupt,
    input  logic         echo_ok,
    input  logic         power_up_done,
    input  logic         rca_status_error,
    input  logic         select_status_error,
    output logic         reset_command_state,
    output logic         start_command,
    output cmd_sel_t     cmd_sel,
    output capture_sel_t capture_sel,
    output logic         mmc_mode,
    output clock_cycle_t mmc_clock_cycle,
    output logic         card_ready
);

    init_state_t state;
    init_state_t next_state;
    logic        error;
    logic [1:0]  reset_pulse_count;

    assign error = response_error | timeout_interrupt;

    always_comb begin
        next_state = state;
        case (state)
            st_init:            if (!command_busy) next_state = st_reset_clk_1;
            st_reset_clk_1:     if (command_busy) next_state = st_reset_clk_2;
            st_reset_clk_2: begin
                if (!command_busy) begin
                    if (reset_pulse_count != 2'd0)
                        next_state = st_reset_clk_1;
                    else
                        next_state = st_send_cmd0;
                end
            end
            st_send_cmd0:       if (command_busy) next_state = st_wait_cmd0;
            st_wait_cmd0:       if (!command_busy) next_state = st_send_dummy;
            st_send_dummy:      if (command_busy) next_state = st_wait_dummy;
            st_wait_dummy: begin
                if (!command_busy)
                    next_state = mmc_mode ? st_send_cmd1 : st_send_cmd8;
            end
            st_send_cmd8:       if (command_busy) next_state = st_resp_cmd8;
            st_resp_cmd8: begin
                // No answer to CMD8 means an MMC card
                if (!command_busy) begin
                    if (timeout_interrupt)
                        next_state = st_send_cmd0;
                    else if (response_error || !echo_ok)
                        next_state = st_init;
                    else
                        next_state = st_send_cmd55;
                end
            end
            st_send_cmd55:      if (command_busy) next_state = st_resp_cmd55;
            st_resp_cmd55: begin
                if (!command_busy)
                    next_state = error ? st_init : st_send_acmd41;
            end
            st_send_acmd41:     if (command_busy) next_state = st_resp_acmd41;
            st_send_cmd1:       if (command_busy) next_state = st_resp_cmd1;
            st_resp_acmd41, st_resp_cmd1: begin
                if (!command_busy) begin
                    if (error)
                        next_state = st_init;
                    else if (power_up_done)
                        next_state = st_send_cmd2;
                    else
                        next_state = st_send_init_dummy;
                end
            end
            st_send_init_dummy: if (command_busy) next_state = st_wait_init_dummy;
            st_wait_init_dummy: begin
                if (!command_busy)
                    next_state = mmc_mode ? st_send_cmd1 : st_send_cmd55;
            end
            st_send_cmd2:       if (command_busy) next_state = st_resp_cmd2;
            st_resp_cmd2: begin
                if (!command_busy)
                    next_state = error ? st_init : st_send_cmd3;
            end
            st_send_cmd3:       if (command_busy) next_state = st_resp_cmd3;
            st_resp_cmd3: begin
                if (!command_busy)
                    next_state = (error || rca_status_error) ? st_init : st_send_cmd9;
            end
            st_send_cmd9:       if (command_busy) next_state = st_resp_cmd9;
            st_resp_cmd9: begin
                if (!command_busy)
                    next_state = error ? st_init : st_send_cmd7;
            end
            st_send_cmd7:       if (command_busy) next_state = st_resp_cmd7;
            st_resp_cmd7: begin
                if (!command_busy)
                    next_state = (error || select_status_error) ? st_init : st_ready;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= st_init;
        else
            state <= next_state;
    end

    always_ff @(posedge clock) begin
        if (reset || state == st_init)
            reset_pulse_count <= reset_pulse_total;
        else if (state == st_reset_clk_1 && command_busy)
            reset_pulse_count <= reset_pulse_count - 2'd1;
    end

    always_ff @(posedge clock) begin
        if (reset || state == st_init)
            mmc_mode <= 1'b0;
        else if (state == st_resp_cmd8 && !command_busy && timeout_interrupt)
            mmc_mode <= 1'b1;
    end

    always_comb begin
        start_command = 1'b1;
        case (state)
            st_reset_clk_1, st_send_dummy, st_send_init_dummy: cmd_sel = sel_dummy;
            st_send_cmd0:   cmd_sel = sel_cmd0;
            st_send_cmd8:   cmd_sel = sel_cmd8;
            st_send_cmd55:  cmd_sel = sel_cmd55;
            st_send_acmd41: cmd_sel = sel_acmd41;
            st_send_cmd1:   cmd_sel = sel_cmd1;
            st_send_cmd2:   cmd_sel = sel_cmd2;
            st_send_cmd3:   cmd_sel = sel_cmd3;
            st_send_cmd9:   cmd_sel = sel_cmd9;
            st_send_cmd7:   cmd_sel = sel_cmd7;
            default: begin
                cmd_sel       = sel_none;
                start_command = 1'b0;
            end
        endcase
    end

    // Response is only valid on the cycle busy drops
    always_comb begin
        capture_sel = cap_none;
        if (!command_busy && !error) begin
            case (state)
                st_resp_acmd41, st_resp_cmd1: capture_sel = cap_ocr;
                st_resp_cmd2:                 capture_sel = cap_cid;
                st_resp_cmd3:                 if (!mmc_mode) capture_sel = cap_rca;
                st_resp_cmd9:                 capture_sel = cap_csd;
                default:                      capture_sel = cap_none;
            endcase
        end
    end

    assign reset_command_state = (state == st_init);
    assign card_ready          = (state == st_ready);
    assign mmc_clock_cycle     = card_ready ? normal_spi_clock_cycle : init_spi_clock_cycle;

    // Request stays up until the command layer takes it
    a_start_held_until_busy: assert property (@(posedge clock) disable iff (reset)
        start_command && !command_busy |=> start_command && $stable(cmd_sel));

    a_capture_on_busy_drop: assert property (@(posedge clock) disable iff (reset)
        capture_sel != cap_none |-> !command_busy && $past(command_busy));

endmodule

`default_nettype wire

/* tb_mmc_init_controller.sv */
//**************************************************
// Testbench for the MMC/SD initialization controller
// Runs SD, MMC and restart bring-up scenarios
//**************************************************
`default_nettype none

module tb_mmc_init_controller
    import mmc_init_pkg::*;
();

    localparam logic [47:0] dummy_frame = '1;

    logic         clock;
    logic         reset;
    logic         reset_command_state;
    logic         start_command;
    cmd_req_t     cmd_req;
    logic         command_busy;
    response_t    response;
    logic         response_error;
    logic         timeout_interrupt;
    clock_cycle_t mmc_clock_cycle;
    logic         card_ready;
    ocr_t         ocr;
    card_id_t     cid;
    card_id_t     csd;
    rca_t         rca;

    // Card profile
    logic         card_is_mmc;
    int           not_ready_count;
    logic         bad_echo_once;
    ocr_t         card_ocr;
    card_id_t     card_cid;
    card_id_t     card_csd;
    rca_t         card_rca;
    logic         frame_strobe;
    cmd_req_t     request_seen;

    logic [47:0]  expected_frames [$];
    cmd_req_t     expected_req;
    logic         ready_expected;
    int           frame_index;
    int           restart_count;
    int           error_count;
    int           check_count;
    int           watchdog_cycles;
    int           random_not_ready;
    int           total_frames;
    integer       seed;

    mmc_init_controller u_mmc_init_controller (
        .clock               (clock),
        .reset               (reset),
        .reset_command_state (reset_command_state),
        .start_command       (start_command),
        .cmd_req             (cmd_req),
        .command_busy        (command_busy),
        .response            (response),
        .response_error      (response_error),
        .timeout_interrupt   (timeout_interrupt),
        .mmc_clock_cycle     (mmc_clock_cycle),
        .card_ready          (card_ready),
        .ocr                 (ocr),
        .cid                 (cid),
        .csd                 (csd),
        .rca                 (rca)
    );

    mmc_card_model u_mmc_card_model (
        .clock             (clock),
        .reset             (reset),
        .start_command     (start_command),
        .cmd_req           (cmd_req),
        .command_busy      (command_busy),
        .response          (response),
        .response_error    (response_error),
        .timeout_interrupt (timeout_interrupt),
        .card_is_mmc       (card_is_mmc),
        .not_ready_count   (not_ready_count),
        .bad_echo_once     (bad_echo_once),
        .card_ocr          (card_ocr),
        .card_cid          (card_cid),
        .card_csd          (card_csd),
        .card_rca          (card_rca),
        .frame_strobe      (frame_strobe),
        .request_seen      (request_seen)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic logic [47:0] make_frame(input cmd_index_t index, input card_arg_t arg);
        return {2'b01, index, arg, 8'h00};
    endfunction

    // CRC enables and response length that go with a frame
    function automatic cmd_req_t expected_request(input logic [47:0] frame);
        cmd_req_t   req;
        cmd_index_t index;
        index                   = frame[45:40];
        req.frame               = frame;
        req.enable_command_crc  = (frame != dummy_frame);
        req.enable_response_crc = (frame != dummy_frame) && (index != cmd_go_idle);
        if (frame == dummy_frame || index == cmd_go_idle)
            req.response_length = 5'd0;
        else if (index == cmd_all_send_cid || index == cmd_send_csd)
            req.response_length = long_response_len;
        else
            req.response_length = short_response_len;
        return req;
    endfunction

    // Expected frame list for one card profile
    function automatic void build_expected(input logic mmc, input int not_ready,
                                           input logic bad_echo, input rca_t profile_rca);
        rca_t addr;
        int   i;
        addr = mmc ? mmc_default_rca : profile_rca;
        expected_frames.delete();
        // A bad echo ends the first pass right after CMD8
        repeat (bad_echo ? 2 : 1) begin
            expected_frames.push_back(dummy_frame);
            expected_frames.push_back(dummy_frame);
            expected_frames.push_back(make_frame(cmd_go_idle, '0));
            expected_frames.push_back(dummy_frame);
            expected_frames.push_back(make_frame(cmd_send_if_cond, if_cond_arg));
        end
        if (mmc) begin
            expected_frames.push_back(make_frame(cmd_go_idle, '0));
            expected_frames.push_back(dummy_frame);
            for (i = 0; i < not_ready; i++) begin
                expected_frames.push_back(make_frame(cmd_send_op_cond, op_cond_arg));
                expected_frames.push_back(dummy_frame);
            end
            expected_frames.push_back(make_frame(cmd_send_op_cond, op_cond_arg));
        end else begin
            for (i = 0; i < not_ready; i++) begin
                expected_frames.push_back(make_frame(cmd_app_cmd, '0));
                expected_frames.push_back(make_frame(acmd_sd_send_op_cond, op_cond_arg));
                expected_frames.push_back(dummy_frame);
            end
            expected_frames.push_back(make_frame(cmd_app_cmd, '0));
            expected_frames.push_back(make_frame(acmd_sd_send_op_cond, op_cond_arg));
        end
        expected_frames.push_back(make_frame(cmd_all_send_cid, '0));
        expected_frames.push_back(make_frame(cmd_send_relative_addr,
                                             mmc ? {mmc_default_rca, 16'h0000} : 32'h0));
        expected_frames.push_back(make_frame(cmd_send_csd, {addr, 16'h0000}));
        expected_frames.push_back(make_frame(cmd_select_card, {addr, 16'h0000}));
    endfunction

    function automatic int expected_length(input logic mmc, input int not_ready,
                                           input logic bad_echo);
        build_expected(mmc, not_ready, bad_echo, 16'h0000);
        return expected_frames.size();
    endfunction

    task automatic compare_value(input string name, input logic [135:0] got,
                                 input logic [135:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // Request checker
    always @(posedge clock) begin
        if (frame_strobe) begin
            if (frame_index < expected_frames.size()) begin
                expected_req = expected_request(expected_frames[frame_index]);
                compare_value($sformatf("frame[%0d]", frame_index), request_seen.frame,
                              expected_req.frame);
                compare_value($sformatf("enable_command_crc[%0d]", frame_index),
                              request_seen.enable_command_crc,
                              expected_req.enable_command_crc);
                compare_value($sformatf("enable_response_crc[%0d]", frame_index),
                              request_seen.enable_response_crc,
                              expected_req.enable_response_crc);
                compare_value($sformatf("response_length[%0d]", frame_index),
                              request_seen.response_length, expected_req.response_length);
            end else begin
                error_count++;
                $display("Unexpected extra frame %h after the expected sequence",
                         request_seen.frame);
            end
            frame_index++;
        end
    end

    // Ready follows the edge that sees the last command answered
    always @(posedge clock) begin
        ready_expected <= !reset && frame_index == expected_frames.size() && !command_busy;
    end

    always @(negedge clock) begin
        if (!reset) begin
            if (reset_command_state && frame_index > 0)
                restart_count++;
            compare_value("card_ready", card_ready, ready_expected);
            compare_value("mmc_clock_cycle", mmc_clock_cycle,
                          ready_expected ? normal_spi_clock_cycle : init_spi_clock_cycle);
        end
    end

    task automatic run_scenario(input string name, input logic mmc, input int not_ready,
                                input logic bad_echo);
        logic [31:0] word;
        @(negedge clock);
        reset           = 1'b1;
        card_is_mmc     = mmc;
        not_ready_count = not_ready;
        bad_echo_once   = bad_echo;
        word            = $random(seed);
        card_ocr        = word | 32'h8000_0000;
        card_cid        = {$random(seed), $random(seed), $random(seed), $random(seed)};
        card_csd        = {$random(seed), $random(seed), $random(seed), $random(seed)};
        word            = $random(seed);
        card_rca        = word[15:0];
        build_expected(mmc, not_ready, bad_echo, card_rca);
        frame_index     = 0;
        restart_count   = 0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        $display("Scenario: %s, %0d frames expected", name, expected_frames.size());
        while (!card_ready)
            @(negedge clock);
        repeat (3) @(negedge clock);
        compare_value("card_ready", card_ready, 1'b1);
        compare_value("frame count", frame_index, expected_frames.size());
        compare_value("ocr", ocr, card_ocr);
        compare_value("cid", cid, card_cid);
        compare_value("csd", csd, card_csd);
        compare_value("rca", rca, mmc ? mmc_default_rca : card_rca);
        if (bad_echo && restart_count == 0) begin
            error_count++;
            $display("The sequence did not restart after the bad CMD8 echo");
        end else if (!bad_echo && restart_count != 0) begin
            error_count++;
            $display("The sequence restarted although no error was reported");
        end
    endtask

    initial begin
        reset           = 1'b1;
        card_is_mmc     = 1'b0;
        not_ready_count = 0;
        bad_echo_once   = 1'b0;
        card_ocr        = '0;
        card_cid        = '0;
        card_csd        = '0;
        card_rca        = '0;
        ready_expected  = 1'b0;
        frame_index     = 0;
        restart_count   = 0;
        error_count     = 0;
        check_count     = 0;
        seed            = 32'h4f96;
        random_not_ready = 1 + ($unsigned($random(seed)) % 5);
        total_frames    = expected_length(1'b0, 0, 1'b0)
                        + expected_length(1'b0, random_not_ready, 1'b0)
                        + expected_length(1'b1, 2, 1'b0)
                        + expected_length(1'b0, 1, 1'b1);
        watchdog_cycles = total_frames * 400;

        run_scenario("SD card, immediate power-up", 1'b0, 0, 1'b0);
        run_scenario("SD card, delayed power-up", 1'b0, random_not_ready, 1'b0);
        run_scenario("MMC card, CMD8 timeout", 1'b1, 2, 1'b0);
        run_scenario("SD card, bad CMD8 echo", 1'b0, 1, 1'b1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles without finishing", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
